/* rtl/riscv_isa_pkg.sv */
package riscv_isa_pkg;

    // ========================================================================
    // major opcodes as found in bits [6:0] of every 32-bit instruction.
    // ========================================================================
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b00_000_11,
        OPC_LOAD_FP   = 7'b00_001_11,
        OPC_CUSTOM_0  = 7'b00_010_11,
        OPC_MISC_MEM  = 7'b00_011_11,
        OPC_OP_IMM    = 7'b00_100_11,
        OPC_AUIPC     = 7'b00_101_11,
        OPC_OP_IMM_32 = 7'b00_110_11,
        OPC_STORE     = 7'b01_000_11,
        OPC_STORE_FP  = 7'b01_001_11,
        OPC_CUSTOM_1  = 7'b01_010_11,
        OPC_AMO       = 7'b01_011_11,
        OPC_OP        = 7'b01_100_11,
        OPC_LUI       = 7'b01_101_11,
        OPC_OP_32     = 7'b01_110_11,
        OPC_MADD      = 7'b10_000_11,
        OPC_MSUB      = 7'b10_001_11,
        OPC_NMSUB     = 7'b10_010_11,
        OPC_NMADD     = 7'b10_011_11,
        OPC_OP_FP     = 7'b10_100_11,
        OPC_CUSTOM_2  = 7'b10_110_11,
        OPC_BRANCH    = 7'b11_000_11,
        OPC_JALR      = 7'b11_001_11,
        OPC_JAL       = 7'b11_011_11,
        OPC_SYSTEM    = 7'b11_100_11,
        OPC_CUSTOM_3  = 7'b11_110_11
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
    } instr_format_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // ========================================================================
    // records passed between the pipeline blocks.
    // ========================================================================
    typedef struct packed {
        opcode_e       opcode;
        instr_format_e format;
        logic [2:0]    funct3;
        logic [6:0]    funct7;
        logic [4:0]    rs1;
        logic [4:0]    rs2;
        logic [4:0]    rd;
        logic          read_enable_1;
        logic          read_enable_2;
        logic          write_enable;
        logic [31:0]   imm;
        logic          supported;
    } decoded_instr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instruction;
    } fetch_packet_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        write;
        logic [31:0] value;
        logic        illegal;
    } retire_t;

endpackage

/* rtl/wishbone_pkg.sv */
package wishbone_pkg;

    // master side of a classic Wishbone cycle.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_request_t;

    // the slave answers with dat valid in the ack cycle.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_response_t;

endpackage

/* rtl/instruction_decoder.sv */
`timescale 1ns/10ps

module instruction_decoder (
    input  logic [31:0]                   instruction,
    output riscv_isa_pkg::decoded_instr_t decoded
);
    import riscv_isa_pkg::*;

    opcode_e       opcode;
    instr_format_e format;
    logic          read_enable_1;
    logic          read_enable_2;
    logic          write_enable;
    logic [31:0]   imm;

    assign opcode = opcode_e'(instruction[6:0]);

    // R is tested first, then I, S, B, U and J.
    always_comb begin
        if (opcode inside {OPC_OP, OPC_OP_32, OPC_OP_FP})
            format = FMT_R;
        else if (opcode inside {OPC_LOAD, OPC_LOAD_FP, OPC_OP_IMM, OPC_OP_IMM_32,
                                OPC_JALR, OPC_MISC_MEM, OPC_SYSTEM})
            format = FMT_I;
        else if (opcode inside {OPC_STORE, OPC_STORE_FP})
            format = FMT_S;
        else if (opcode == OPC_BRANCH)
            format = FMT_B;
        else if (opcode inside {OPC_AUIPC, OPC_LUI})
            format = FMT_U;
        else if (opcode == OPC_JAL)
            format = FMT_J;
        else
            format = FMT_NONE;
    end

    always_comb begin
        read_enable_1 = 1'b0;
        read_enable_2 = 1'b0;
        write_enable  = 1'b0;
        imm           = 32'd0;
        case (format)
            FMT_R: begin
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                write_enable  = 1'b1;
            end
            FMT_I: begin
                read_enable_1 = 1'b1;
                write_enable  = 1'b1;
                imm = {{20{instruction[31]}}, instruction[31:20]};
            end
            FMT_S: begin
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
            end
            FMT_B: begin
                read_enable_1 = 1'b1;
                read_enable_2 = 1'b1;
                imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            FMT_U: begin
                write_enable = 1'b1;
                imm = {instruction[31:12], 12'd0};
            end
            FMT_J: begin
                write_enable = 1'b1;
                imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: begin
            end
        endcase

        // x0 is hardwired, so a write to it is dropped here.
        if (instruction[11:7] == 5'd0)
            write_enable = 1'b0;
    end

    assign decoded.opcode        = opcode;
    assign decoded.format        = format;
    assign decoded.funct3        = instruction[14:12];
    assign decoded.funct7        = instruction[31:25];
    assign decoded.rs1           = instruction[19:15];
    assign decoded.rs2           = instruction[24:20];
    assign decoded.rd            = instruction[11:7];
    assign decoded.read_enable_1 = read_enable_1;
    assign decoded.read_enable_2 = read_enable_2;
    assign decoded.write_enable  = write_enable;
    assign decoded.imm           = imm;
    assign decoded.supported     = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC};

endmodule

/* rtl/register_file.sv */
`timescale 1ns/10ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  read_index_1,
    input  logic [4:0]  read_index_2,
    output logic [31:0] read_data_1,
    output logic [31:0] read_data_2,
    input  logic        write_enable,
    input  logic [4:0]  write_index,
    input  logic [31:0] write_data
);

    logic [31:0] registers [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                registers[i] <= 32'd0;
        end else if (write_enable && write_index != 5'd0) begin
            registers[write_index] <= write_data;
        end
    end

    // reads see the value before any write in the same cycle.
    assign read_data_1 = (read_index_1 == 5'd0) ? 32'd0 : registers[read_index_1];
    assign read_data_2 = (read_index_2 == 5'd0) ? 32'd0 : registers[read_index_2];

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit #(
    parameter logic [31:0] reset_vector = 32'h0000_0000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         halt,
    output wishbone_pkg::wb_request_t    wb_out,
    input  wishbone_pkg::wb_response_t   wb_in,
    output riscv_isa_pkg::fetch_packet_t fetch
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        GAP
    } fetch_state_e;

    fetch_state_e state;
    logic [31:0]  pc;

    // ========================================================================
    // bus cycle control. A GAP cycle follows every ack so that cyc drops.
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= reset_vector;
        end else begin
            case (state)
                IDLE:    if (!halt) state <= REQUEST;
                REQUEST: begin
                    if (wb_in.ack) begin
                        state <= GAP;
                        pc    <= pc + 32'd4;
                    end
                end
                GAP:     state <= halt ? IDLE : REQUEST;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch.valid <= 1'b0;
        end else begin
            fetch.valid <= (state == REQUEST) && wb_in.ack;
            if (state == REQUEST && wb_in.ack) begin
                fetch.pc          <= pc;
                fetch.instruction <= wb_in.dat;
            end
        end
    end

    assign wb_out.cyc = (state == REQUEST);
    assign wb_out.stb = (state == REQUEST);
    assign wb_out.we  = 1'b0;
    assign wb_out.adr = pc;
    assign wb_out.dat = 32'd0;
    assign wb_out.sel = 4'hf;

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  riscv_isa_pkg::fetch_packet_t  fetch,
    input  riscv_isa_pkg::decoded_instr_t decoded,
    input  logic [31:0]                   read_data_1,
    input  logic [31:0]                   read_data_2,
    output logic                          write_enable,
    output logic [4:0]                    write_index,
    output logic [31:0]                   write_data,
    output riscv_isa_pkg::retire_t        retire
);
    import riscv_isa_pkg::*;

    alu_op_e     alu_op;
    logic [31:0] operand_a;
    logic [31:0] operand_b;
    logic [31:0] result;

    // funct7 bit 5 picks SUB and SRA for OP, and only SRAI for OP_IMM.
    always_comb begin
        alu_op = ALU_ADD;
        if (decoded.opcode == OPC_LUI) begin
            alu_op = ALU_PASS_B;
        end else if (decoded.opcode inside {OPC_OP, OPC_OP_IMM}) begin
            case (decoded.funct3)
                3'b000: begin
                    if (decoded.opcode == OPC_OP && decoded.funct7[5])
                        alu_op = ALU_SUB;
                end
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = decoded.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign operand_a = (decoded.opcode == OPC_AUIPC) ? fetch.pc : read_data_1;
    assign operand_b = (decoded.opcode == OPC_OP) ? read_data_2 : decoded.imm;

    always_comb begin
        case (alu_op)
            ALU_SUB:    result = operand_a - operand_b;
            ALU_SLL:    result = operand_a << operand_b[4:0];
            ALU_SLT:    result = {31'd0, $signed(operand_a) < $signed(operand_b)};
            ALU_SLTU:   result = {31'd0, operand_a < operand_b};
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_SRL:    result = operand_a >> operand_b[4:0];
            ALU_SRA:    result = $signed(operand_a) >>> operand_b[4:0];
            ALU_OR:     result = operand_a | operand_b;
            ALU_AND:    result = operand_a & operand_b;
            ALU_PASS_B: result = operand_b;
            default:    result = operand_a + operand_b;
        endcase
    end

    assign write_enable = fetch.valid && decoded.write_enable && decoded.supported;
    assign write_index  = decoded.rd;
    assign write_data   = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= fetch.valid;
            if (fetch.valid) begin
                retire.pc      <= fetch.pc;
                retire.rd      <= decoded.rd;
                retire.write   <= decoded.write_enable && decoded.supported;
                retire.value   <= decoded.supported ? result : 32'd0;
                retire.illegal <= !decoded.supported;
            end
        end
    end

endmodule

/* rtl/rv_execute_core.sv */
`timescale 1ns/10ps

module rv_execute_core #(
    parameter logic [31:0] reset_vector = 32'h0000_0000
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       halt,
    output wishbone_pkg::wb_request_t  wb_out,
    input  wishbone_pkg::wb_response_t wb_in,
    output riscv_isa_pkg::retire_t     retire
);
    import riscv_isa_pkg::*;

    fetch_packet_t  fetch;
    decoded_instr_t decoded;
    logic [31:0]    read_data_1;
    logic [31:0]    read_data_2;
    logic           write_enable;
    logic [4:0]     write_index;
    logic [31:0]    write_data;

    fetch_unit #(
        .reset_vector(reset_vector)
    ) fetch_unit_inst (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .wb_out(wb_out),
        .wb_in (wb_in),
        .fetch (fetch)
    );

    instruction_decoder instruction_decoder_inst (
        .instruction(fetch.instruction),
        .decoded    (decoded)
    );

    register_file register_file_inst (
        .clk         (clk),
        .reset       (reset),
        .read_index_1(decoded.rs1),
        .read_index_2(decoded.rs2),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .write_enable(write_enable),
        .write_index (write_index),
        .write_data  (write_data)
    );

    execute_stage execute_stage_inst (
        .clk         (clk),
        .reset       (reset),
        .fetch       (fetch),
        .decoded     (decoded),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .write_enable(write_enable),
        .write_index (write_index),
        .write_data  (write_data),
        .retire      (retire)
    );

endmodule

/* include/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// columns are instruction word, rd, write, value and illegal.
// the program sits at reset_vector, and expected values assume it is 32'h0000_0100.
typedef struct packed {
    logic [31:0] instruction;
    logic [4:0]  rd;
    logic        write;
    logic [31:0] value;
    logic        illegal;
} program_row_t;

localparam int program_length = 33;

localparam program_row_t program_rows [program_length] = '{
    // x1 = -5 and x2 = 12, then the immediate forms of every OP_IMM function.
    '{32'hFFB00093, 5'd1,  1'b1, 32'hFFFFFFFB, 1'b0},
    '{32'h00C00113, 5'd2,  1'b1, 32'h0000000C, 1'b0},
    '{32'hFFC0A193, 5'd3,  1'b1, 32'h00000001, 1'b0},
    '{32'h00C0B213, 5'd4,  1'b1, 32'h00000000, 1'b0},
    '{32'h0F014293, 5'd5,  1'b1, 32'h000000FC, 1'b0},
    '{32'hF0016313, 5'd6,  1'b1, 32'hFFFFFF0C, 1'b0},
    '{32'h0FF0F393, 5'd7,  1'b1, 32'h000000FB, 1'b0},
    '{32'h01C11413, 5'd8,  1'b1, 32'hC0000000, 1'b0},
    '{32'h00445493, 5'd9,  1'b1, 32'h0C000000, 1'b0},
    '{32'h40445513, 5'd10, 1'b1, 32'hFC000000, 1'b0},
    // LUI feeds the overflow and shift cases of the register-register forms.
    '{32'h002085B3, 5'd11, 1'b1, 32'h00000007, 1'b0},
    '{32'h40208633, 5'd12, 1'b1, 32'hFFFFFFEF, 1'b0},
    '{32'h800006B7, 5'd13, 1'b1, 32'h80000000, 1'b0},
    '{32'hFFF68713, 5'd14, 1'b1, 32'h7FFFFFFF, 1'b0},
    '{32'h00E707B3, 5'd15, 1'b1, 32'hFFFFFFFE, 1'b0},
    '{32'h00111833, 5'd16, 1'b1, 32'h60000000, 1'b0},
    '{32'h0020A8B3, 5'd17, 1'b1, 32'h00000001, 1'b0},
    '{32'h0020B933, 5'd18, 1'b1, 32'h00000000, 1'b0},
    '{32'h0020C9B3, 5'd19, 1'b1, 32'hFFFFFFF7, 1'b0},
    '{32'h0026DA33, 5'd20, 1'b1, 32'h00080000, 1'b0},
    '{32'h4026DAB3, 5'd21, 1'b1, 32'hFFF80000, 1'b0},
    '{32'h0020EB33, 5'd22, 1'b1, 32'hFFFFFFFF, 1'b0},
    '{32'h0020FBB3, 5'd23, 1'b1, 32'h00000008, 1'b0},
    // auipc at index 23, then a write to x0 and a read of x0.
    '{32'h12345C17, 5'd24, 1'b1, 32'h1234515C, 1'b0},
    '{32'h00510013, 5'd0,  1'b0, 32'h00000011, 1'b0},
    '{32'h00200CB3, 5'd25, 1'b1, 32'h0000000C, 1'b0},
    // lw, sw, beq, jal, jalr and ecall, then x1 is read back untouched.
    '{32'h0000AD03, 5'd26, 1'b0, 32'h00000000, 1'b1},
    '{32'h0020A223, 5'd4,  1'b0, 32'h00000000, 1'b1},
    '{32'h00208463, 5'd8,  1'b0, 32'h00000000, 1'b1},
    '{32'h010000EF, 5'd1,  1'b0, 32'h00000000, 1'b1},
    '{32'h000082E7, 5'd5,  1'b0, 32'h00000000, 1'b1},
    '{32'h00000073, 5'd0,  1'b0, 32'h00000000, 1'b1},
    '{32'h00008D93, 5'd27, 1'b1, 32'hFFFFFFFB, 1'b0}
};

`endif

/* testbench/tb_rv_execute_core.sv */
`timescale 1ns/10ps

module tb_rv_execute_core;
    import riscv_isa_pkg::*;
    import wishbone_pkg::*;

    localparam logic [31:0] reset_vector = 32'h0000_0100;
    localparam int halt_after_row = 12;

    `include "tb_program.svh"

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         halt = 1'b0;
    wb_request_t  wb_out;
    wb_response_t wb_in = '0;
    retire_t      retire;
    int           ack_delay = 0;
    int           retired = 0;

    rv_execute_core #(
        .reset_vector(reset_vector)
    ) rv_execute_core_inst (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .wb_out(wb_out),
        .wb_in (wb_in),
        .retire(retire)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    // addresses past the table read as an addi to x0 whose immediate folds the address.
    function automatic logic [31:0] fetch_word(input logic [31:0] adr);
        logic [31:0] index;
        logic [11:0] fill;
        index = (adr - reset_vector) >> 2;
        fill  = adr[31:20] ^ adr[19:8] ^ {4'd0, adr[7:0]};
        if (index < program_length)
            return program_rows[index].instruction;
        else
            return {fill, 20'h00013};
    endfunction

    // ========================================================================
    // the wishbone slave acks after a random wait of 0 to 3 cycles.
    // ========================================================================
    always @(posedge clk) begin
        #1;
        if (reset) begin
            wb_in.ack = 1'b0;
            ack_delay = $urandom_range(3, 0);
        end else if (wb_in.ack) begin
            wb_in.ack = 1'b0;
            ack_delay = $urandom_range(3, 0);
        end else if (wb_out.cyc && wb_out.stb) begin
            check_value("wb_out.we", {31'd0, wb_out.we}, 32'd0);
            check_value("wb_out.sel", {28'd0, wb_out.sel}, 32'h0000_000f);
            check_value("wb_out.adr[1:0]", {30'd0, wb_out.adr[1:0]}, 32'd0);
            if (ack_delay == 0) begin
                wb_in.ack = 1'b1;
                wb_in.dat = fetch_word(wb_out.adr);
            end else begin
                ack_delay--;
            end
        end
    end

    task automatic wait_for_retire(input int row);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!retire.valid && cycles < 50);
        if (!retire.valid)
            report_timeout($sformatf("the retire of row %0d", row));
    endtask

    // ========================================================================
    // halt stretch. Once the bus has gone idle no instruction may retire.
    // ========================================================================
    initial begin : halt_control
        int cycles;
        cycles = 0;
        while (retired < halt_after_row && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (retired < halt_after_row)
            report_timeout("the row that raises halt");
        #1 halt = 1'b1;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (wb_out.cyc && cycles < 50);
        if (wb_out.cyc)
            report_timeout("the bus to go idle under halt");
        // the last acked word still retires within the next two cycles.
        repeat (3) @(negedge clk);
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            check_value("retire.valid", {31'd0, retire.valid}, 32'd0);
            check_value("wb_out.cyc", {31'd0, wb_out.cyc}, 32'd0);
        end
        @(posedge clk);
        #1 halt = 1'b0;
    end

    initial begin
        program_row_t row;
        void'($urandom(48358));
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < program_length; i++) begin
            wait_for_retire(i);
            row = program_rows[i];
            check_value($sformatf("retire.pc[%0d]", i), retire.pc,
                        reset_vector + 32'(4 * i));
            check_value($sformatf("retire.rd[%0d]", i), {27'd0, retire.rd}, {27'd0, row.rd});
            check_value($sformatf("retire.write[%0d]", i), {31'd0, retire.write},
                        {31'd0, row.write});
            check_value($sformatf("retire.value[%0d]", i), retire.value, row.value);
            check_value($sformatf("retire.illegal[%0d]", i), {31'd0, retire.illegal},
                        {31'd0, row.illegal});
            retired = i + 1;
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
rtl/riscv_isa_pkg.sv
rtl/wishbone_pkg.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
rtl/fetch_unit.sv
rtl/execute_stage.sv
rtl/rv_execute_core.sv
testbench/tb_rv_execute_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f tb.f \
    --top-module tb_rv_execute_core -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_rv_execute_core > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
